//--- Bender.yml
package:
  name: mister_io

sources:
  - mister_cfg_pkg.sv
  - mister_status_regs.sv
  - user_port_mux.sv
  - ps2_mouse_decode.sv
  - hdmi_crop_ctrl.sv
  - mister_io_top.sv
  - target: test
    files:
      - tb_mister_io.sv

//--- build.f
mister_cfg_pkg.sv
mister_status_regs.sv
user_port_mux.sv
ps2_mouse_decode.sv
hdmi_crop_ctrl.sv
mister_io_top.sv
tb_mister_io.sv

//--- hdmi_crop_ctrl.sv
// HDMI vertical crop eligibility check with crop size and offset computation
`timescale 1ns/1ps

module hdmi_crop_ctrl #(
    parameter int unsigned CROP_LINES = 216,
    parameter int unsigned NATIVE_W   = 1920,
    parameter int unsigned NATIVE_H   = 1080
) (
    input  logic        clk_sys,
    input  logic        arst_n,
    input  logic [11:0] hdmi_width,
    input  logic [11:0] hdmi_height,
    input  logic [2:0]  fx_level,
    input  logic        force_scan2x,
    input  logic [1:0]  crop_scale,
    input  logic        direct_video,
    input  logic        rotate_en,
    input  logic        crop_en,
    input  logic [3:0]  vcopt,
    output logic        crop_ok,
    output logic [11:0] crop_size,
    output logic [4:0]  crop_off
);

    logic       native_res;
    logic       plain_video;
    logic [4:0] vc_twice;
    logic [4:0] off_d;

    // Only a full 1080p output leaves room for a 216 line crop
    assign native_res = (hdmi_width == 12'(NATIVE_W)) && (hdmi_height == 12'(NATIVE_H));

    // Scanline FX, integer scaling, scan doubler, direct video and rotation all conflict
    assign plain_video = (fx_level == 3'd0) && (crop_scale == 2'd0) && !force_scan2x
                         && !direct_video && !rotate_en;

    // Offset steps of two lines, upper options wrap to negative
    assign vc_twice = {vcopt, 1'b0};
    assign off_d    = (vcopt < 4'd6) ? vc_twice : vc_twice - 5'd24;

    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            crop_ok  <= 1'b0;
            crop_off <= '0;
        end else begin
            crop_ok  <= native_res && plain_video;
            crop_off <= off_d;
        end
    end

    // Follows the registered eligibility, one cycle behind it
    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            crop_size <= '0;
        end else if (crop_ok && crop_en) begin
            crop_size <= 12'(CROP_LINES);
        end else begin
            crop_size <= '0;
        end
    end

endmodule

//--- mister_cfg_pkg.sv
// Shared widths, APB register map, status bit positions and enums for the I/O shell
package mister_cfg_pkg;

    // Bus and field widths
    parameter int unsigned status_w      = 64;
    parameter int unsigned apb_addr_w    = 4;
    parameter int unsigned apb_data_w    = 32;
    parameter int unsigned user_port_w   = 7;
    parameter int unsigned mouse_delta_w = 9;

    // APB register map, byte addresses
    typedef enum logic [apb_addr_w-1:0] {
        REG_STATUS_LO = 4'h0,
        REG_STATUS_HI = 4'h4,
        REG_CORE_MOD  = 4'h8,
        REG_MENU_MASK = 4'hC
    } reg_sel_t;

    typedef enum logic [1:0] {
        APB_IDLE,
        APB_SETUP,
        APB_ACCESS
    } apb_phase_t;

    typedef enum logic [1:0] {
        PORT_IDLE,
        PORT_DB15,
        PORT_UART
    } port_mode_t;

    // OSD status word layout
    parameter int unsigned st_fx_lsb          = 3;
    parameter int unsigned st_db15_bit        = 37;
    parameter int unsigned st_uart_bit        = 38;
    parameter int unsigned st_crop_en_bit     = 41;
    parameter int unsigned st_vcopt_lsb       = 42;
    parameter int unsigned st_crop_scale_lsb  = 46;
    parameter int unsigned st_hsize_en_bit    = 48;
    parameter int unsigned st_hsize_scale_lsb = 49;
    parameter int unsigned st_hoffset_lsb     = 53;
    parameter int unsigned st_voffset_lsb     = 57;

endpackage

//--- mister_io_stim.txt
# Commands for tb_mister_io; values in hex, wait and mouse counts in decimal
# write ADDR DATA ERR | read ADDR DATA ERR | set NAME VAL | wait N | check NAME VAL | mouse N
check mouse_valid 0
check crop_size 0
check user_out 7f
read 0 00000000 0
write 0 a5a5a5a5 0
write 4 0d370000 0
check hoffset 9
check voffset 6
check hsize_enable 1
check hsize_scale b
write 8 0000007e 0
write c 0000ffff 1
write e 12345678 1
read e 00000000 1
read 0 a5a5a5a5 0
read 4 0d370000 0
read 8 0000007e 0
read c 0000001a 0
write 8 0000007f 0
read c 00000018 0
set direct_video 1
wait 1
read c 00000019 0
set direct_video 0
write 4 01e20000 0
check hoffset f
check voffset 0
check hsize_enable 0
check hsize_scale 1
read c 0000001c 0
set user_in 7d
set joy_drive 55
set game_tx 0
write 4 00000040 0
check game_rx 0
wait 1
check user_out 7e
write 4 00000060 0
check game_rx 1
wait 1
check user_out 55
write 4 00000000 0
wait 1
check user_out 7f
check game_rx 1
mouse 10
write 0 00000000 0
set hdmi_width 780
set hdmi_height 438
wait 1
read c 0000003c 0
write 4 00000200 0
wait 2
check crop_size d8
check crop_off 0
write 4 00001600 0
wait 1
check crop_off a
write 4 00001a00 0
wait 1
check crop_off 14
write 4 00003e00 0
wait 1
check crop_off 6
check crop_size d8
set hdmi_width 500
wait 1
check crop_size d8
wait 1
check crop_size 0
read c 0000001c 0

//--- mister_io_top.sv
// Top level of the I/O shell joining the register bank, port mux, mouse and crop logic
`timescale 1ns/1ps

module mister_io_top import mister_cfg_pkg::*; #(
    parameter int unsigned CROP_LINES = 216,
    parameter int unsigned NATIVE_W   = 1920,
    parameter int unsigned NATIVE_H   = 1080
) (
    input  logic                     clk_sys,
    input  logic                     arst_n,
    input  logic [apb_addr_w-1:0]    paddr,
    input  logic                     psel,
    input  logic                     penable,
    input  logic                     pwrite,
    input  logic [apb_data_w-1:0]    pwdata,
    output logic [apb_data_w-1:0]    prdata,
    output logic                     pready,
    output logic                     pslverr,
    input  logic [user_port_w-1:0]   user_in,
    input  logic [user_port_w-1:0]   joy_drive,
    input  logic                     game_tx,
    output logic [user_port_w-1:0]   user_out,
    output logic                     game_rx,
    input  logic [24:0]              ps2_mouse,
    output logic                     mouse_valid,
    output logic [mouse_delta_w-1:0] mouse_dx,
    output logic [mouse_delta_w-1:0] mouse_dy,
    output logic [7:0]               mouse_flags,
    input  logic [11:0]              hdmi_width,
    input  logic [11:0]              hdmi_height,
    input  logic                     force_scan2x,
    input  logic                     direct_video,
    input  logic                     rotate_en,
    output logic [11:0]              crop_size,
    output logic [4:0]               crop_off,
    output logic [3:0]               hoffset,
    output logic [3:0]               voffset,
    output logic                     hsize_enable,
    output logic [3:0]               hsize_scale
);

    port_mode_t port_mode;
    logic       crop_en;
    logic [3:0] vcopt;
    logic [1:0] crop_scale;
    logic [2:0] fx_level;
    logic       crop_ok;

    mister_status_regs u_regs (
        .clk_sys      ( clk_sys      ),
        .arst_n       ( arst_n       ),
        .paddr        ( paddr        ),
        .psel         ( psel         ),
        .penable      ( penable      ),
        .pwrite       ( pwrite       ),
        .pwdata       ( pwdata       ),
        .direct_video ( direct_video ),
        .crop_ok      ( crop_ok      ),
        .prdata       ( prdata       ),
        .pready       ( pready       ),
        .pslverr      ( pslverr      ),
        .port_mode    ( port_mode    ),
        .crop_en      ( crop_en      ),
        .vcopt        ( vcopt        ),
        .crop_scale   ( crop_scale   ),
        .fx_level     ( fx_level     ),
        .hoffset      ( hoffset      ),
        .voffset      ( voffset      ),
        .hsize_enable ( hsize_enable ),
        .hsize_scale  ( hsize_scale  )
    );

    user_port_mux u_port (
        .clk_sys   ( clk_sys   ),
        .arst_n    ( arst_n    ),
        .port_mode ( port_mode ),
        .user_in   ( user_in   ),
        .joy_drive ( joy_drive ),
        .game_tx   ( game_tx   ),
        .user_out  ( user_out  ),
        .game_rx   ( game_rx   )
    );

    ps2_mouse_decode u_mouse (
        .clk_sys     ( clk_sys     ),
        .arst_n      ( arst_n      ),
        .ps2_mouse   ( ps2_mouse   ),
        .mouse_valid ( mouse_valid ),
        .mouse_dx    ( mouse_dx    ),
        .mouse_dy    ( mouse_dy    ),
        .mouse_flags ( mouse_flags )
    );

    // Eligibility goes back to the register bank for the menu mask
    hdmi_crop_ctrl #(
        .CROP_LINES ( CROP_LINES ),
        .NATIVE_W   ( NATIVE_W   ),
        .NATIVE_H   ( NATIVE_H   )
    ) u_crop (
        .clk_sys      ( clk_sys      ),
        .arst_n       ( arst_n       ),
        .hdmi_width   ( hdmi_width   ),
        .hdmi_height  ( hdmi_height  ),
        .fx_level     ( fx_level     ),
        .force_scan2x ( force_scan2x ),
        .crop_scale   ( crop_scale   ),
        .direct_video ( direct_video ),
        .rotate_en    ( rotate_en    ),
        .crop_en      ( crop_en      ),
        .vcopt        ( vcopt        ),
        .crop_ok      ( crop_ok      ),
        .crop_size    ( crop_size    ),
        .crop_off     ( crop_off     )
    );

endmodule

//--- mister_status_regs.sv
// APB slave holding the OSD status word and core mode, with setting decode and menu mask
`timescale 1ns/1ps

module mister_status_regs import mister_cfg_pkg::*; (
    input  logic                  clk_sys,
    input  logic                  arst_n,
    input  logic [apb_addr_w-1:0] paddr,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [apb_data_w-1:0] pwdata,
    input  logic                  direct_video,
    input  logic                  crop_ok,
    output logic [apb_data_w-1:0] prdata,
    output logic                  pready,
    output logic                  pslverr,
    output port_mode_t            port_mode,
    output logic                  crop_en,
    output logic [3:0]            vcopt,
    output logic [1:0]            crop_scale,
    output logic [2:0]            fx_level,
    output logic [3:0]            hoffset,
    output logic [3:0]            voffset,
    output logic                  hsize_enable,
    output logic [3:0]            hsize_scale
);

    apb_phase_t            phase_q;
    apb_phase_t            phase_d;
    reg_sel_t              sel;
    logic [status_w-1:0]   status_q;
    logic [6:0]            core_mod_q;
    logic [15:0]           menu_mask;
    logic [apb_data_w-1:0] rd_data;
    logic                  addr_ok;
    logic                  bad_access;
    logic                  in_access;
    logic                  wr_en;

    // Bus phase of the current cycle, registered copy tells a fresh access apart
    always_comb begin
        if (!psel) begin
            phase_d = APB_IDLE;
        end else if (!penable) begin
            phase_d = APB_SETUP;
        end else begin
            phase_d = APB_ACCESS;
        end
    end

    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            phase_q <= APB_IDLE;
        end else begin
            phase_q <= phase_d;
        end
    end

    assign sel = reg_sel_t'(paddr);

    // Register decode and readback mux
    always_comb begin
        addr_ok = 1'b1;
        rd_data = '0;
        case (sel)
            REG_STATUS_LO: rd_data = status_q[apb_data_w-1:0];
            REG_STATUS_HI: rd_data = status_q[status_w-1:apb_data_w];
            REG_CORE_MOD:  rd_data = {{(apb_data_w-7){1'b0}}, core_mod_q};
            REG_MENU_MASK: rd_data = {{(apb_data_w-16){1'b0}}, menu_mask};
            default:       addr_ok = 1'b0;
        endcase
    end

    // Menu mask is read only
    assign bad_access = !addr_ok || (pwrite && sel == REG_MENU_MASK);
    assign in_access  = (phase_d == APB_ACCESS);
    assign wr_en      = in_access && phase_q == APB_SETUP && pwrite && !bad_access;

    // No wait states
    assign pready  = in_access;
    assign pslverr = in_access && bad_access;
    assign prdata  = (in_access && !pwrite) ? rd_data : '0;

    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            status_q   <= '0;
            core_mod_q <= '0;
        end else if (wr_en) begin
            case (sel)
                REG_STATUS_LO: status_q[apb_data_w-1:0]        <= pwdata;
                REG_STATUS_HI: status_q[status_w-1:apb_data_w] <= pwdata;
                REG_CORE_MOD:  core_mod_q                      <= pwdata[6:0];
                default:       core_mod_q                      <= core_mod_q;
            endcase
        end
    end

    // DB15 wins over UART
    always_comb begin
        if (status_q[st_db15_bit]) begin
            port_mode = PORT_DB15;
        end else if (status_q[st_uart_bit]) begin
            port_mode = PORT_UART;
        end else begin
            port_mode = PORT_IDLE;
        end
    end

    assign crop_en      = status_q[st_crop_en_bit];
    assign vcopt        = status_q[st_vcopt_lsb +: 4];
    assign crop_scale   = status_q[st_crop_scale_lsb +: 2];
    assign fx_level     = status_q[st_fx_lsb +: 3];
    assign hoffset      = status_q[st_hoffset_lsb +: 4];
    assign voffset      = status_q[st_voffset_lsb +: 4];
    assign hsize_enable = status_q[st_hsize_en_bit];
    assign hsize_scale  = status_q[st_hsize_scale_lsb +: 4];

    // A high bit hides the OSD item; rotation and 60 Hz items always hidden
    assign menu_mask = {10'd0, crop_ok, 1'b1, 1'b1, ~hsize_enable, ~core_mod_q[0],
                        direct_video};

endmodule

//--- ps2_mouse_decode.sv
// PS/2 mouse packet toggle detector and signed motion decoder
`timescale 1ns/1ps

module ps2_mouse_decode import mister_cfg_pkg::*; (
    input  logic                     clk_sys,
    input  logic                     arst_n,
    input  logic [24:0]              ps2_mouse,
    output logic                     mouse_valid,
    output logic [mouse_delta_w-1:0] mouse_dx,
    output logic [mouse_delta_w-1:0] mouse_dy,
    output logic [7:0]               mouse_flags
);

    logic       toggle_q;
    logic       new_pkt;
    logic [7:0] pkt_flags;

    // Host flips bit 24 on every fresh packet
    assign new_pkt   = ps2_mouse[24] ^ toggle_q;
    assign pkt_flags = ps2_mouse[7:0];

    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            toggle_q    <= 1'b0;
            mouse_valid <= 1'b0;
        end else begin
            toggle_q    <= ps2_mouse[24];
            mouse_valid <= new_pkt;
        end
    end

    // Sign bits sit in the flag byte, bits 4 and 5
    always_ff @(posedge clk_sys) begin
        if (new_pkt) begin
            mouse_flags <= pkt_flags;
            mouse_dx    <= {pkt_flags[4], ps2_mouse[15:8]};
            mouse_dy    <= {pkt_flags[5], ps2_mouse[23:16]};
        end
    end

endmodule

//--- tb_mister_io.sv
// Self-checking testbench for the I/O shell driven by a command file
`timescale 1ns/1ps

module tb_mister_io import mister_cfg_pkg::*; ();

    logic                     clk_sys;
    logic                     arst_n;
    logic [apb_addr_w-1:0]    paddr;
    logic                     psel;
    logic                     penable;
    logic                     pwrite;
    logic [apb_data_w-1:0]    pwdata;
    logic [apb_data_w-1:0]    prdata;
    logic                     pready;
    logic                     pslverr;
    logic [user_port_w-1:0]   user_in;
    logic [user_port_w-1:0]   joy_drive;
    logic                     game_tx;
    logic [user_port_w-1:0]   user_out;
    logic                     game_rx;
    logic [24:0]              ps2_mouse;
    logic                     mouse_valid;
    logic [mouse_delta_w-1:0] mouse_dx;
    logic [mouse_delta_w-1:0] mouse_dy;
    logic [7:0]               mouse_flags;
    logic [11:0]              hdmi_width;
    logic [11:0]              hdmi_height;
    logic                     force_scan2x;
    logic                     direct_video;
    logic                     rotate_en;
    logic [11:0]              crop_size;
    logic [4:0]               crop_off;
    logic [3:0]               hoffset;
    logic [3:0]               voffset;
    logic                     hsize_enable;
    logic [3:0]               hsize_scale;

    integer seed;
    integer cycle_cnt;
    integer cycle_limit;

    mister_io_top u_dut (.*);

    always #20 clk_sys = ~clk_sys;

    // Run limit set once the command file has been sized
    always @(posedge clk_sys) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("Timeout: run went past %0d clock cycles", cycle_limit);
            abort_run();
        end
    end

    task automatic abort_run();
        $display("RESULT: FAIL");
        $fatal(1, "run stopped after an error");
    endtask

    task automatic report_mismatch(input string sig, input logic [31:0] exp_v,
                                   input logic [31:0] act_v);
        $display("[FAIL] t=%0t %s expected %0h actual %0h", $time, sig, exp_v, act_v);
        abort_run();
    endtask

    task automatic expect_eq(input string sig, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
        assert (act_v === exp_v) else report_mismatch(sig, exp_v, act_v);
    endtask

    // Two's complement motion value from the sign flag and the low byte
    function automatic logic [8:0] motion_value(input logic sign, input logic [7:0] mag);
        integer v;
        v = mag;
        if (sign) begin
            v = v - 256;
        end
        return v[8:0];
    endfunction

    // One APB transfer without wait states
    // Status sampled in the middle of the access phase
    task automatic apb_access(input logic wr, input logic [31:0] addr,
                              input logic [31:0] value, input logic exp_err);
        paddr   = addr[apb_addr_w-1:0];
        pwrite  = wr;
        pwdata  = wr ? value : '0;
        psel    = 1'b1;
        penable = 1'b0;
        @(posedge clk_sys);
        #2;
        penable = 1'b1;
        #1;
        expect_eq("pready", 1, pready);
        expect_eq("pslverr", exp_err, pslverr);
        if (!wr) begin
            expect_eq("prdata", value, prdata);
        end
        @(posedge clk_sys);
        #2;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic drive_input(input string sig, input logic [31:0] val);
        case (sig)
            "user_in":      user_in      = val[user_port_w-1:0];
            "joy_drive":    joy_drive    = val[user_port_w-1:0];
            "game_tx":      game_tx      = val[0];
            "hdmi_width":   hdmi_width   = val[11:0];
            "hdmi_height":  hdmi_height  = val[11:0];
            "force_scan2x": force_scan2x = val[0];
            "direct_video": direct_video = val[0];
            "rotate_en":    rotate_en    = val[0];
            default: begin
                $display("Stimulus file names an unknown input: %s", sig);
                abort_run();
            end
        endcase
    endtask

    task automatic check_output(input string sig, input logic [31:0] exp_v);
        logic [31:0] act;
        logic        known;
        act   = '0;
        known = 1'b1;
        case (sig)
            "user_out":     act = user_out;
            "game_rx":      act = game_rx;
            "mouse_valid":  act = mouse_valid;
            "crop_size":    act = crop_size;
            "crop_off":     act = crop_off;
            "hoffset":      act = hoffset;
            "voffset":      act = voffset;
            "hsize_enable": act = hsize_enable;
            "hsize_scale":  act = hsize_scale;
            default:        known = 1'b0;
        endcase
        if (known) begin
            expect_eq(sig, exp_v, act);
        end else begin
            $display("Stimulus file names an unknown output: %s", sig);
            abort_run();
        end
    endtask

    // Random packets with fresh toggles followed by one packet without a toggle
    task automatic mouse_burst(input integer count);
        logic [24:0] pkt;
        logic [8:0]  exp_dx;
        logic [8:0]  exp_dy;
        integer      i;
        for (i = 0; i < count; i = i + 1) begin
            pkt       = $random(seed);
            pkt[24]   = ~ps2_mouse[24];
            ps2_mouse = pkt;
            exp_dx    = motion_value(pkt[4], pkt[15:8]);
            exp_dy    = motion_value(pkt[5], pkt[23:16]);
            @(posedge clk_sys);
            #1;
            expect_eq("mouse_valid", 1, mouse_valid);
            expect_eq("mouse_dx", exp_dx, mouse_dx);
            expect_eq("mouse_dy", exp_dy, mouse_dy);
            expect_eq("mouse_flags", pkt[7:0], mouse_flags);
            @(posedge clk_sys);
            #1;
            expect_eq("mouse_valid", 0, mouse_valid);
            #1;
        end
        ps2_mouse[23:0] = ~ps2_mouse[23:0];
        repeat (2) begin
            @(posedge clk_sys);
            #1;
            expect_eq("mouse_valid", 0, mouse_valid);
            #1;
        end
        // Motion holds from the last real packet
        expect_eq("mouse_dx", exp_dx, mouse_dx);
    endtask

    // Dry pass only adds up cycles while the live pass drives the DUT
    task automatic run_stim(input bit dry, inout integer total);
        string             op;
        string             sig;
        logic [31:0]       a1;
        logic [31:0]       a2;
        logic [31:0]       a3;
        logic [8*128-1:0]  skip_line;
        integer            fd;
        integer            code;
        fd = $fopen("mister_io_stim.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file mister_io_stim.txt");
            abort_run();
        end else begin
            while ($fscanf(fd, "%s", op) == 1) begin
                if (op == "#") begin
                    code = $fgets(skip_line, fd);
                end else if (op == "write" || op == "read") begin
                    code = $fscanf(fd, "%h %h %h", a1, a2, a3);
                    if (dry) begin
                        total = total + 2;
                    end else begin
                        apb_access(op == "write", a1, a2, a3[0]);
                    end
                end else if (op == "set" || op == "check") begin
                    code = $fscanf(fd, "%s %h", sig, a1);
                    if (!dry && op == "set") begin
                        drive_input(sig, a1);
                    end else if (!dry) begin
                        check_output(sig, a1);
                    end
                end else if (op == "wait") begin
                    code = $fscanf(fd, "%d", a1);
                    if (dry) begin
                        total = total + a1;
                    end else begin
                        repeat (a1) @(posedge clk_sys);
                        #2;
                    end
                end else if (op == "mouse") begin
                    code = $fscanf(fd, "%d", a1);
                    if (dry) begin
                        total = total + 2 * a1 + 2;
                    end else begin
                        mouse_burst(a1);
                    end
                end else begin
                    $display("Stimulus file holds an unknown command: %s", op);
                    abort_run();
                end
            end
            $fclose(fd);
        end
    endtask

    initial begin
        integer total;
        total        = 10;
        seed         = 32'h6df9;
        cycle_cnt    = 0;
        cycle_limit  = 0;
        clk_sys      = 1'b0;
        arst_n       = 1'b0;
        paddr        = '0;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        pwdata       = '0;
        user_in      = '0;
        joy_drive    = '0;
        game_tx      = 1'b1;
        ps2_mouse    = '0;
        hdmi_width   = '0;
        hdmi_height  = '0;
        force_scan2x = 1'b0;
        direct_video = 1'b0;
        rotate_en    = 1'b0;
        run_stim(1'b1, total);
        cycle_limit = 2 * total + 200;
        repeat (10) @(posedge clk_sys);
        #2;
        arst_n = 1'b1;
        run_stim(1'b0, total);
        $display("RESULT: PASS");
        $finish;
    end

endmodule

//--- user_port_mux.sv
// Extension connector multiplexer between DB15 joystick adapter, UART and idle
`timescale 1ns/1ps

module user_port_mux import mister_cfg_pkg::*; (
    input  logic                   clk_sys,
    input  logic                   arst_n,
    input  port_mode_t             port_mode,
    input  logic [user_port_w-1:0] user_in,
    input  logic [user_port_w-1:0] joy_drive,
    input  logic                   game_tx,
    output logic [user_port_w-1:0] user_out,
    output logic                   game_rx
);

    logic [user_port_w-1:0] out_d;

    // Connector pins idle high
    always_comb begin
        case (port_mode)
            PORT_DB15: begin
                out_d = joy_drive;
            end
            PORT_UART: begin
                // TX on pin 0, rest released
                out_d = {{(user_port_w-1){1'b1}}, game_tx};
            end
            default: begin
                out_d = '1;
            end
        endcase
    end

    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            user_out <= '1;
        end else begin
            user_out <= out_d;
        end
    end

    // RX comes in on pin 1, idle line is high
    assign game_rx = (port_mode == PORT_UART) ? user_in[1] : 1'b1;

endmodule
